/* rtl/ppu_pkg.sv */
package ppu_pkg;

  // default posit width, the top level may pass its own N down
  localparam int unsigned N_DEFAULT = 16;

  typedef logic [N_DEFAULT-1:0] posit_t;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2,
    DIV = 2'd3
  } operation_e;

  // zero is all bits clear, NaR has only the sign bit set
  localparam posit_t ZERO = '0;
  localparam posit_t NAR  = {1'b1, {(N_DEFAULT-1){1'b0}}};

  // negating a posit is a plain two's complement of its bit pattern
  function automatic posit_t c2(input posit_t p);
    return posit_t'(~p + 1'b1);
  endfunction

endpackage

/* rtl/ppu_bus_pkg.sv */
package ppu_bus_pkg;

  typedef logic [31:0] apb_data_t;
  typedef logic [7:0]  apb_addr_t;
  typedef logic [2:0]  bank_idx_t;

  // register map, word aligned
  localparam apb_addr_t REG_OP_A   = 8'h00;
  localparam apb_addr_t REG_OP_B   = 8'h04;
  localparam apb_addr_t REG_CMD    = 8'h08;
  localparam apb_addr_t REG_RESULT = 8'h0C;
  localparam apb_addr_t REG_STATUS = 8'h10;

  // bank entry for each register
  localparam bank_idx_t IDX_OP_A   = 3'd0;
  localparam bank_idx_t IDX_OP_B   = 3'd1;
  localparam bank_idx_t IDX_CMD    = 3'd2;
  localparam bank_idx_t IDX_RESULT = 3'd3;
  localparam bank_idx_t IDX_STATUS = 3'd4;

  localparam int unsigned STAT_BUSY     = 0;
  localparam int unsigned STAT_DONE     = 1;
  localparam int unsigned STAT_RESOLVED = 2;

endpackage

/* rtl/ppu_bank_if.sv */
`timescale 1ns/1ps

interface ppu_bank_if;

  logic                   req;
  logic                   we;
  ppu_bus_pkg::bank_idx_t idx;
  ppu_bus_pkg::apb_data_t wdata;
  logic                   gnt;
  ppu_bus_pkg::apb_data_t rdata;

  // a requester holds its fields until gnt, the access completes in that cycle
  modport requester (
    output req, we, idx, wdata,
    input  gnt, rdata
  );

  modport bank (
    input  req, we, idx, wdata,
    output gnt, rdata
  );

endinterface

/* rtl/handle_special_or_trivial.sv */
`timescale 1ns/1ps

module handle_special_or_trivial #(
  parameter int unsigned N = ppu_pkg::N_DEFAULT
) (
  input  ppu_pkg::operation_e op_i,
  input  ppu_pkg::posit_t     p1_i,
  input  ppu_pkg::posit_t     p2_i,
  output ppu_pkg::posit_t     pout_o
);

  ppu_pkg::posit_t mul_out;
  ppu_pkg::posit_t add_out;
  ppu_pkg::posit_t sub_out;
  ppu_pkg::posit_t div_out;

  // the tables only work on the package posit width
  if (N != $bits(ppu_pkg::posit_t)) begin : g_width_check
    $error("posit width %0d does not match ppu_pkg::posit_t", N);
  end

  lut_mul u_lut_mul (
    .p1_i   (p1_i),
    .p2_i   (p2_i),
    .pout_o (mul_out)
  );

  lut_add u_lut_add (
    .p1_i   (p1_i),
    .p2_i   (p2_i),
    .pout_o (add_out)
  );

  lut_sub u_lut_sub (
    .p1_i   (p1_i),
    .p2_i   (p2_i),
    .pout_o (sub_out)
  );

  lut_div u_lut_div (
    .p1_i   (p1_i),
    .p2_i   (p2_i),
    .pout_o (div_out)
  );

  always_comb begin
    case (op_i)
      ppu_pkg::ADD: pout_o = add_out;
      ppu_pkg::SUB: pout_o = sub_out;
      ppu_pkg::MUL: pout_o = mul_out;
      default:      pout_o = div_out;
    endcase
  end

endmodule

module lut_mul (
  input  ppu_pkg::posit_t p1_i,
  input  ppu_pkg::posit_t p2_i,
  output ppu_pkg::posit_t pout_o
);

  always_comb begin
    if (p1_i == ppu_pkg::NAR || p2_i == ppu_pkg::NAR) begin
      pout_o = ppu_pkg::NAR;
    end else begin
      pout_o = ppu_pkg::ZERO;
    end
  end

endmodule

module lut_add (
  input  ppu_pkg::posit_t p1_i,
  input  ppu_pkg::posit_t p2_i,
  output ppu_pkg::posit_t pout_o
);

  always_comb begin
    if (p1_i == ppu_pkg::NAR || p2_i == ppu_pkg::NAR) begin
      pout_o = ppu_pkg::NAR;
    end else if (p1_i == ppu_pkg::ZERO) begin
      pout_o = p2_i;
    end else if (p2_i == ppu_pkg::ZERO) begin
      pout_o = p1_i;
    end else begin
      // x plus its negation cancels exactly
      pout_o = ppu_pkg::ZERO;
    end
  end

endmodule

module lut_sub (
  input  ppu_pkg::posit_t p1_i,
  input  ppu_pkg::posit_t p2_i,
  output ppu_pkg::posit_t pout_o
);

  always_comb begin
    if (p1_i == ppu_pkg::NAR || p2_i == ppu_pkg::NAR) begin
      pout_o = ppu_pkg::NAR;
    end else if (p1_i == ppu_pkg::ZERO) begin
      pout_o = ppu_pkg::c2(p2_i);
    end else if (p2_i == ppu_pkg::ZERO) begin
      pout_o = p1_i;
    end else begin
      pout_o = ppu_pkg::ZERO;
    end
  end

endmodule

module lut_div (
  input  ppu_pkg::posit_t p1_i,
  input  ppu_pkg::posit_t p2_i,
  output ppu_pkg::posit_t pout_o
);

  // division by zero is NaR, so only a zero dividend gives zero
  always_comb begin
    if (p1_i == ppu_pkg::ZERO && p2_i != ppu_pkg::ZERO && p2_i != ppu_pkg::NAR) begin
      pout_o = ppu_pkg::ZERO;
    end else begin
      pout_o = ppu_pkg::NAR;
    end
  end

endmodule

/* rtl/ppu_apb_slave.sv */
`timescale 1ns/1ps

module ppu_apb_slave (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  ppu_bus_pkg::apb_addr_t paddr_i,
  input  ppu_bus_pkg::apb_data_t pwdata_i,
  output ppu_bus_pkg::apb_data_t prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  ppu_bank_if.requester          bank_o
);

  logic                   access;
  logic                   addr_err;
  ppu_bus_pkg::bank_idx_t idx;

  assign access = psel_i & penable_i;

  // result and status are read only for software
  always_comb begin
    addr_err = 1'b0;
    idx      = ppu_bus_pkg::IDX_OP_A;
    case (paddr_i)
      ppu_bus_pkg::REG_OP_A:   idx = ppu_bus_pkg::IDX_OP_A;
      ppu_bus_pkg::REG_OP_B:   idx = ppu_bus_pkg::IDX_OP_B;
      ppu_bus_pkg::REG_CMD:    idx = ppu_bus_pkg::IDX_CMD;
      ppu_bus_pkg::REG_RESULT: begin
        idx      = ppu_bus_pkg::IDX_RESULT;
        addr_err = pwrite_i;
      end
      ppu_bus_pkg::REG_STATUS: begin
        idx      = ppu_bus_pkg::IDX_STATUS;
        addr_err = pwrite_i;
      end
      default: addr_err = 1'b1;
    endcase
  end

  // an erroring access never reaches the bank
  assign bank_o.req   = access & ~addr_err;
  assign bank_o.we    = pwrite_i;
  assign bank_o.idx   = idx;
  assign bank_o.wdata = pwdata_i;

  assign pready_o  = access & (addr_err | bank_o.gnt);
  assign pslverr_o = access & addr_err;
  assign prdata_o  = addr_err ? '0 : bank_o.rdata;

  a_setup_before_enable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $rose(penable_i) |-> $past(psel_i)
  );

endmodule

/* rtl/ppu_shared_bank.sv */
`timescale 1ns/1ps

module ppu_shared_bank #(
  parameter int unsigned N = ppu_pkg::N_DEFAULT
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  ppu_bank_if.bank            apb_i,
  ppu_bank_if.bank            eng_i,
  output logic                start_o,
  output ppu_pkg::operation_e op_o
);

  localparam int unsigned NUM_ENTRIES = 5;
  localparam ppu_bus_pkg::apb_data_t OPERAND_MASK =
    ppu_bus_pkg::apb_data_t'((64'd1 << N) - 64'd1);

  ppu_bus_pkg::apb_data_t entries_q [NUM_ENTRIES];
  logic                   prio_eng_q;
  logic                   wr_en;
  ppu_bus_pkg::bank_idx_t wr_idx;
  ppu_bus_pkg::apb_data_t wr_data;
  logic                   cmd_wr;

  // round robin, the peer served last loses a tie
  assign apb_i.gnt = apb_i.req & (~eng_i.req | ~prio_eng_q);
  assign eng_i.gnt = eng_i.req & (~apb_i.req | prio_eng_q);

  always_comb begin
    apb_i.rdata = '0;
    eng_i.rdata = '0;
    if (apb_i.idx < NUM_ENTRIES) begin
      apb_i.rdata = entries_q[apb_i.idx];
    end
    if (eng_i.idx < NUM_ENTRIES) begin
      eng_i.rdata = entries_q[eng_i.idx];
    end
  end

  always_comb begin
    wr_en   = 1'b0;
    wr_idx  = apb_i.idx;
    wr_data = apb_i.wdata;
    if (apb_i.gnt) begin
      wr_en = apb_i.we;
    end else if (eng_i.gnt) begin
      wr_en   = eng_i.we;
      wr_idx  = eng_i.idx;
      wr_data = eng_i.wdata;
    end
    if (wr_idx == ppu_bus_pkg::IDX_OP_A || wr_idx == ppu_bus_pkg::IDX_OP_B) begin
      wr_data = wr_data & OPERAND_MASK;
    end
  end

  assign cmd_wr = apb_i.gnt & apb_i.we & (apb_i.idx == ppu_bus_pkg::IDX_CMD);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        entries_q[i] <= '0;
      end
      prio_eng_q <= 1'b0;
      start_o    <= 1'b0;
      op_o       <= ppu_pkg::ADD;
    end else begin
      if (wr_en && wr_idx < NUM_ENTRIES) begin
        entries_q[wr_idx] <= wr_data;
      end
      if (apb_i.gnt) begin
        prio_eng_q <= 1'b1;
      end else if (eng_i.gnt) begin
        prio_eng_q <= 1'b0;
      end
      start_o <= cmd_wr;
      if (cmd_wr) begin
        op_o <= ppu_pkg::operation_e'(apb_i.wdata[1:0]);
      end
    end
  end

  a_single_grant: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(apb_i.gnt && eng_i.gnt)
  );

endmodule

/* rtl/ppu_engine.sv */
`timescale 1ns/1ps

module ppu_engine #(
  parameter int unsigned N = ppu_pkg::N_DEFAULT
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                start_i,
  input  ppu_pkg::operation_e op_i,
  ppu_bank_if.requester       bank_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WR_BUSY,
    S_RD_A,
    S_RD_B,
    S_WR_RES,
    S_WR_DONE
  } state_e;

  state_e                 state_q;
  state_e                 state_d;
  ppu_pkg::operation_e    op_q;
  ppu_pkg::posit_t        op_a_q;
  ppu_pkg::posit_t        op_b_q;
  ppu_pkg::posit_t        handler_out;
  logic                   resolvable;
  ppu_bus_pkg::apb_data_t status_word;

  handle_special_or_trivial #(
    .N (N)
  ) u_handler (
    .op_i   (op_q),
    .p1_i   (op_a_q),
    .p2_i   (op_b_q),
    .pout_o (handler_out)
  );

  always_comb begin
    resolvable = (op_a_q == ppu_pkg::ZERO) || (op_a_q == ppu_pkg::NAR) ||
                 (op_b_q == ppu_pkg::ZERO) || (op_b_q == ppu_pkg::NAR);
    if (op_q == ppu_pkg::ADD && op_b_q == ppu_pkg::c2(op_a_q)) begin
      resolvable = 1'b1;
    end
    if (op_q == ppu_pkg::SUB && op_b_q == op_a_q) begin
      resolvable = 1'b1;
    end
  end

  always_comb begin
    status_word = '0;
    status_word[ppu_bus_pkg::STAT_DONE]     = 1'b1;
    status_word[ppu_bus_pkg::STAT_RESOLVED] = resolvable;
  end

  // one bank access per state, each state waits for its grant
  always_comb begin
    state_d      = state_q;
    bank_o.req   = 1'b1;
    bank_o.we    = 1'b0;
    bank_o.idx   = ppu_bus_pkg::IDX_STATUS;
    bank_o.wdata = '0;
    case (state_q)
      S_IDLE: begin
        bank_o.req = 1'b0;
        if (start_i) state_d = S_WR_BUSY;
      end
      S_WR_BUSY: begin
        bank_o.we = 1'b1;
        bank_o.wdata[ppu_bus_pkg::STAT_BUSY] = 1'b1;
        if (bank_o.gnt) state_d = S_RD_A;
      end
      S_RD_A: begin
        bank_o.idx = ppu_bus_pkg::IDX_OP_A;
        if (bank_o.gnt) state_d = S_RD_B;
      end
      S_RD_B: begin
        bank_o.idx = ppu_bus_pkg::IDX_OP_B;
        if (bank_o.gnt) state_d = S_WR_RES;
      end
      S_WR_RES: begin
        bank_o.we    = 1'b1;
        bank_o.idx   = ppu_bus_pkg::IDX_RESULT;
        bank_o.wdata = resolvable ? ppu_bus_pkg::apb_data_t'(handler_out) : '0;
        if (bank_o.gnt) state_d = S_WR_DONE;
      end
      default: begin
        bank_o.we    = 1'b1;
        bank_o.wdata = status_word;
        if (bank_o.gnt) state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= S_IDLE;
      op_q    <= ppu_pkg::ADD;
    end else begin
      state_q <= state_d;
      if (state_q == S_IDLE && start_i) begin
        op_q <= op_i;
      end
    end
  end

  // operands are payload, captured on the grant of their read
  always_ff @(posedge clk_i) begin
    if (state_q == S_RD_A && bank_o.gnt) begin
      op_a_q <= bank_o.rdata[N-1:0];
    end
    if (state_q == S_RD_B && bank_o.gnt) begin
      op_b_q <= bank_o.rdata[N-1:0];
    end
  end

  a_req_only_when_running: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    bank_o.req |-> state_q != S_IDLE
  );

endmodule

/* rtl/ppu_top.sv */
`timescale 1ns/1ps

module ppu_top #(
  parameter int unsigned N = ppu_pkg::N_DEFAULT
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  ppu_bus_pkg::apb_addr_t paddr_i,
  input  ppu_bus_pkg::apb_data_t pwdata_i,
  output ppu_bus_pkg::apb_data_t prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  ppu_bank_if apb_bank ();
  ppu_bank_if eng_bank ();

  logic                start;
  ppu_pkg::operation_e op;

  ppu_apb_slave u_apb_slave (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .bank_o    (apb_bank.requester)
  );

  ppu_shared_bank #(
    .N (N)
  ) u_bank (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .apb_i   (apb_bank.bank),
    .eng_i   (eng_bank.bank),
    .start_o (start),
    .op_o    (op)
  );

  ppu_engine #(
    .N (N)
  ) u_engine (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (start),
    .op_i    (op),
    .bank_o  (eng_bank.requester)
  );

endmodule

/* include/ppu_ref_model.svh */
`ifndef PPU_REF_MODEL_SVH
`define PPU_REF_MODEL_SVH

// true when the engine can settle the pair without a full datapath
function automatic bit pair_resolvable(input ppu_pkg::operation_e op,
                                       input ppu_pkg::posit_t a,
                                       input ppu_pkg::posit_t b);
  ppu_pkg::posit_t neg_a;
  neg_a = -a;
  if (a == ppu_pkg::ZERO || a == ppu_pkg::NAR) return 1'b1;
  if (b == ppu_pkg::ZERO || b == ppu_pkg::NAR) return 1'b1;
  if (op == ppu_pkg::ADD && b == neg_a) return 1'b1;
  if (op == ppu_pkg::SUB && a == b) return 1'b1;
  return 1'b0;
endfunction

// expected RESULT register, zero for pairs that stay unresolved
function automatic ppu_pkg::posit_t expected_result(input ppu_pkg::operation_e op,
                                                    input ppu_pkg::posit_t a,
                                                    input ppu_pkg::posit_t b);
  ppu_pkg::posit_t neg_b;
  neg_b = -b;
  if (!pair_resolvable(op, a, b)) return ppu_pkg::ZERO;
  if (a == ppu_pkg::NAR || b == ppu_pkg::NAR) return ppu_pkg::NAR;
  case (op)
    ppu_pkg::MUL: return ppu_pkg::ZERO;
    ppu_pkg::ADD: begin
      if (a == ppu_pkg::ZERO) return b;
      if (b == ppu_pkg::ZERO) return a;
      return ppu_pkg::ZERO;
    end
    ppu_pkg::SUB: begin
      if (a == ppu_pkg::ZERO) return neg_b;
      if (b == ppu_pkg::ZERO) return a;
      return ppu_pkg::ZERO;
    end
    default: begin
      if (b == ppu_pkg::ZERO) return ppu_pkg::NAR;
      return ppu_pkg::ZERO;
    end
  endcase
endfunction

`endif

/* verification/tb_ppu.sv */
`timescale 1ns/1ps

module tb_ppu;

  localparam int unsigned N          = 16;
  localparam int unsigned WAIT_LIMIT = 50;
  localparam int unsigned POLL_LIMIT = 40;
  localparam int unsigned PAIRS      = 16;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  ppu_bus_pkg::apb_addr_t paddr_i;
  ppu_bus_pkg::apb_data_t pwdata_i;
  ppu_bus_pkg::apb_data_t prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;

  int error_count = 0;
  int check_count = 0;
  int tests_run   = 0;

  `include "ppu_ref_model.svh"

  ppu_top #(
    .N (N)
  ) u_dut (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic end_run();
    $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    $display("test %0d %s: %0d errors", tests_run, name, error_count - errors_before);
  endtask

  // setup phase, access phase, then hold until pready_o, sampled on the falling edge
  task automatic apb_access(input bit write, input ppu_bus_pkg::apb_addr_t addr,
                            input ppu_bus_pkg::apb_data_t wdata,
                            output ppu_bus_pkg::apb_data_t rdata, output logic slverr);
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    paddr_i   <= addr;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!pready_o && cycles < WAIT_LIMIT);
    if (!pready_o) begin
      $display("timeout: access to address %h got no pready_o in %0d cycles", addr, cycles);
      error_count++;
      end_run();
    end else begin
      rdata  = prdata_o;
      slverr = pslverr_o;
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
    end
  endtask

  task automatic write_reg(input ppu_bus_pkg::apb_addr_t addr, input ppu_bus_pkg::apb_data_t data,
                           input logic exp_err);
    ppu_bus_pkg::apb_data_t unused;
    logic                   slverr;
    apb_access(1'b1, addr, data, unused, slverr);
    compare($sformatf("pslverr_o on write to %h", addr), slverr, exp_err);
  endtask

  task automatic read_reg(input ppu_bus_pkg::apb_addr_t addr, input logic exp_err,
                          output ppu_bus_pkg::apb_data_t data);
    logic slverr;
    apb_access(1'b0, addr, '0, data, slverr);
    compare($sformatf("pslverr_o on read of %h", addr), slverr, exp_err);
  endtask

  task automatic poll_done(output ppu_bus_pkg::apb_data_t status);
    int polls;
    polls = 0;
    do begin
      read_reg(ppu_bus_pkg::REG_STATUS, 1'b0, status);
      polls++;
    end while (!(status[ppu_bus_pkg::STAT_DONE] && !status[ppu_bus_pkg::STAT_BUSY]) &&
               polls < POLL_LIMIT);
    if (!status[ppu_bus_pkg::STAT_DONE] || status[ppu_bus_pkg::STAT_BUSY]) begin
      $display("timeout: STATUS never showed DONE after %0d polls", polls);
      error_count++;
      end_run();
    end
  endtask

  // busy_reads status reads are issued right after the command, while the run is going
  task automatic run_case(input ppu_pkg::operation_e op, input ppu_pkg::posit_t a,
                          input ppu_pkg::posit_t b, input int busy_reads);
    ppu_bus_pkg::apb_data_t status;
    ppu_bus_pkg::apb_data_t result;
    write_reg(ppu_bus_pkg::REG_OP_A, {16'h0, a}, 1'b0);
    write_reg(ppu_bus_pkg::REG_OP_B, {16'h0, b}, 1'b0);
    write_reg(ppu_bus_pkg::REG_CMD, {30'h0, op}, 1'b0);
    for (int i = 0; i < busy_reads; i++) begin
      read_reg(ppu_bus_pkg::REG_STATUS, 1'b0, status);
    end
    poll_done(status);
    read_reg(ppu_bus_pkg::REG_RESULT, 1'b0, result);
    compare($sformatf("RESULT %s %h %h", op.name(), a, b), result,
            {16'h0, expected_result(op, a, b)});
    compare($sformatf("STATUS.resolved %s %h %h", op.name(), a, b),
            status[ppu_bus_pkg::STAT_RESOLVED], pair_resolvable(op, a, b));
  endtask

  function automatic ppu_pkg::posit_t negate(input ppu_pkg::posit_t p);
    return (~p) + 16'd1;
  endfunction

  function automatic ppu_pkg::posit_t draw_operand();
    case ($urandom_range(0, 4))
      0: return ppu_pkg::ZERO;
      1: return ppu_pkg::NAR;
      default: return ppu_pkg::posit_t'($urandom());
    endcase
  endfunction

  // second operand favours copies of the first so that cancellation shows up often
  function automatic ppu_pkg::posit_t draw_partner(input ppu_pkg::posit_t other);
    case ($urandom_range(0, 5))
      0: return ppu_pkg::ZERO;
      1: return ppu_pkg::NAR;
      2: return negate(other);
      3: return other;
      default: return ppu_pkg::posit_t'($urandom());
    endcase
  endfunction

  ppu_bus_pkg::apb_data_t rd;
  ppu_bus_pkg::apb_data_t wr;
  ppu_bus_pkg::apb_data_t snap [4];
  ppu_pkg::posit_t        a;
  ppu_pkg::posit_t        b;
  int                     errors_before;

  initial begin
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    rst_n_i   = 1'b0;
    void'($urandom(32'hfca9904e));
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    errors_before = error_count;
    @(negedge clk_i);
    compare("pready_o", pready_o, 1'b0);
    compare("pslverr_o", pslverr_o, 1'b0);
    read_reg(ppu_bus_pkg::REG_RESULT, 1'b0, rd);
    compare("RESULT after reset", rd, '0);
    read_reg(ppu_bus_pkg::REG_STATUS, 1'b0, rd);
    compare("STATUS after reset", rd, '0);
    report_test("reset values", errors_before);

    errors_before = error_count;
    for (int i = 0; i < 8; i++) begin
      wr = $urandom();
      write_reg(ppu_bus_pkg::REG_OP_A, wr, 1'b0);
      read_reg(ppu_bus_pkg::REG_OP_A, 1'b0, rd);
      compare("OP_A readback", rd, wr & 32'h0000_ffff);
      wr = $urandom();
      write_reg(ppu_bus_pkg::REG_OP_B, wr, 1'b0);
      read_reg(ppu_bus_pkg::REG_OP_B, 1'b0, rd);
      compare("OP_B readback", rd, wr & 32'h0000_ffff);
    end
    report_test("operand readback", errors_before);

    errors_before = error_count;
    for (int i = 0; i < PAIRS; i++) begin
      for (int k = 0; k < 4; k++) begin
        a = draw_operand();
        b = draw_partner(a);
        run_case(ppu_pkg::operation_e'(k), a, b, 0);
      end
    end
    report_test("random operations", errors_before);

    errors_before = error_count;
    read_reg(ppu_bus_pkg::REG_OP_A, 1'b0, snap[0]);
    read_reg(ppu_bus_pkg::REG_OP_B, 1'b0, snap[1]);
    read_reg(ppu_bus_pkg::REG_RESULT, 1'b0, snap[2]);
    read_reg(ppu_bus_pkg::REG_STATUS, 1'b0, snap[3]);
    write_reg(ppu_bus_pkg::REG_RESULT, 32'hdead_beef, 1'b1);
    write_reg(ppu_bus_pkg::REG_STATUS, 32'h0000_0007, 1'b1);
    write_reg(8'h14, 32'h1234_5678, 1'b1);
    read_reg(8'h20, 1'b1, rd);
    read_reg(ppu_bus_pkg::REG_OP_A, 1'b0, rd);
    compare("OP_A after bad accesses", rd, snap[0]);
    read_reg(ppu_bus_pkg::REG_OP_B, 1'b0, rd);
    compare("OP_B after bad accesses", rd, snap[1]);
    read_reg(ppu_bus_pkg::REG_RESULT, 1'b0, rd);
    compare("RESULT after bad accesses", rd, snap[2]);
    read_reg(ppu_bus_pkg::REG_STATUS, 1'b0, rd);
    compare("STATUS after bad accesses", rd, snap[3]);
    report_test("slave errors", errors_before);

    errors_before = error_count;
    for (int k = 0; k < 4; k++) begin
      a = draw_operand();
      b = draw_partner(a);
      run_case(ppu_pkg::operation_e'(k), a, b, 6);
    end
    report_test("reads during a run", errors_before);

    end_run();
  end

endmodule

/* verilog.f */
+incdir+include
rtl/ppu_pkg.sv
rtl/ppu_bus_pkg.sv
rtl/ppu_bank_if.sv
rtl/handle_special_or_trivial.sv
rtl/ppu_apb_slave.sv
rtl/ppu_shared_bank.sv
rtl/ppu_engine.sv
rtl/ppu_top.sv
verification/tb_ppu.sv

/* Bender.yml */
package:
  name: ppu

sources:
  - files:
      - rtl/ppu_pkg.sv
      - rtl/ppu_bus_pkg.sv
      - rtl/ppu_bank_if.sv
      - rtl/handle_special_or_trivial.sv
      - rtl/ppu_apb_slave.sv
      - rtl/ppu_shared_bank.sv
      - rtl/ppu_engine.sv
      - rtl/ppu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_ppu.sv
